// File: src/pa_pkg.sv
package pa_pkg;

	// ALU built from four 4-bit slices
	localparam int SLICES = 4;
	localparam int SLICE_W = 4;

	// bit 0 is the most significant everywhere
	typedef logic [0:SLICES*SLICE_W-1] word_t;
	typedef logic [0:SLICE_W-1] nibble_t;
	typedef logic [0:7] byte_t;

	// slice function select, s3..s0
	typedef logic [3:0] alu_fn_t;

	// W bus source and A operand source selects
	typedef logic [2:0] wsel_t;
	typedef logic [1:0] asel_t;

	// AR decrement step
	localparam word_t AR_STEP_DN = 16'd4;

endpackage

// File: src/pa_wbus.sv
`timescale 1ns/1ps

module pa_wbus (
	input  pa_pkg::word_t ir,
	input  pa_pkg::word_t ki,
	input  pa_pkg::word_t rdt,
	input  pa_pkg::word_t kl,
	input  pa_pkg::word_t a,
	input  pa_pkg::word_t ac,
	input  pa_pkg::word_t at,
	input  pa_pkg::wsel_t wsel,
	input  logic blank_hi,
	input  logic blank_lo,
	input  logic w_dt,
	output pa_pkg::word_t w,
	output pa_pkg::word_t ddt
);

	pa_pkg::byte_t w_hi;
	pa_pkg::byte_t w_lo;

	// each byte is selected on its own so that source 4 can swap
	always_comb begin
		case (wsel)
			3'd0: w_hi = a[0:7];
			3'd1: w_hi = ac[0:7];
			3'd2: w_hi = at[0:7];
			3'd3: w_hi = ki[0:7];
			3'd4: w_hi = 8'd0;
			3'd5: w_hi = rdt[0:7];
			3'd6: w_hi = kl[0:7];
			default: w_hi = ir[0:7];
		endcase
		if (blank_hi) begin
			w_hi = 8'd0;
		end
	end

	always_comb begin
		case (wsel)
			3'd0: w_lo = a[8:15];
			3'd1: w_lo = ac[8:15];
			3'd2: w_lo = at[8:15];
			3'd3: w_lo = ki[8:15];
			// high byte of ac moved down
			3'd4: w_lo = ac[0:7];
			3'd5: w_lo = rdt[8:15];
			3'd6: w_lo = kl[8:15];
			default: w_lo = ir[8:15];
		endcase
		if (blank_lo) begin
			w_lo = 8'd0;
		end
	end

	assign w = {w_hi, w_lo};

	// data bus carries W only when enabled
	assign ddt = w_dt ? w : '0;

endmodule

// File: src/pa_amux.sv
`timescale 1ns/1ps

module pa_amux (
	input  pa_pkg::word_t l,
	input  pa_pkg::word_t ir,
	input  pa_pkg::word_t ar,
	input  pa_pkg::word_t ic,
	input  pa_pkg::asel_t asel,
	input  logic blank_a0,
	input  logic blank_a8,
	input  logic blank_a10,
	output pa_pkg::word_t a
);

	pa_pkg::word_t src;

	always_comb begin
		case (asel)
			2'd0: src = l;
			2'd1: src = ar;
			2'd2: src = ic;
			// low byte of l on top, low byte of ir below
			default: src = {l[8:15], ir[8:15]};
		endcase
	end

	// three groups blanked independently
	assign a[0:7] = blank_a0 ? 8'd0 : src[0:7];
	assign a[8:9] = blank_a8 ? 2'd0 : src[8:9];
	assign a[10:15] = blank_a10 ? 6'd0 : src[10:15];

endmodule

// File: src/alu_slice.sv
`timescale 1ns/1ps

module alu_slice (
	input  pa_pkg::nibble_t a,
	input  pa_pkg::nibble_t b,
	input  pa_pkg::alu_fn_t fn,
	input  logic logic_mode,
	input  logic cin,
	output pa_pkg::nibble_t f,
	output logic p,
	output logic g,
	output logic eq,
	output logic cout
);

	// per-bit terms of the 181: y is the first addend, x the second
	pa_pkg::nibble_t y;
	pa_pkg::nibble_t x;
	logic [0:pa_pkg::SLICE_W] sum;

	assign y = a
		| (b & {pa_pkg::SLICE_W{fn[0]}})
		| (~b & {pa_pkg::SLICE_W{fn[1]}});

	assign x = (a & ~b & {pa_pkg::SLICE_W{fn[2]}})
		| (a & b & {pa_pkg::SLICE_W{fn[3]}});

	// x is a subset of y, so y^x is the half sum
	assign sum = {1'b0, y} + {1'b0, x} + {{pa_pkg::SLICE_W{1'b0}}, cin};

	assign f = logic_mode ? ~(y ^ x) : sum[1:pa_pkg::SLICE_W];

	// group terms for the lookahead unit
	assign p = &y;
	assign g = x[0]
		| (y[0] & x[1])
		| (y[0] & y[1] & x[2])
		| (y[0] & y[1] & y[2] & x[3]);

	assign cout = g | (p & cin);

	// A=B output: all result bits high
	assign eq = &f;

endmodule

// File: src/pa_alu.sv
`timescale 1ns/1ps

module pa_alu (
	input  pa_pkg::word_t a,
	input  pa_pkg::word_t b,
	input  pa_pkg::alu_fn_t fn_hi,
	input  pa_pkg::alu_fn_t fn_lo,
	input  logic logic_mode,
	input  logic cin,
	output pa_pkg::word_t f,
	output logic carry,
	output pa_pkg::nibble_t eqv
);

	logic [0:pa_pkg::SLICES-1] p;
	logic [0:pa_pkg::SLICES-1] g;
	logic [0:pa_pkg::SLICES-1] c;
	logic [0:pa_pkg::SLICES-1] co;

	// slice 0 holds bits 0..3, the most significant
	for (genvar k = 0; k < pa_pkg::SLICES; k++) begin : g_slice
		alu_slice slice (
			.a(a[k*pa_pkg::SLICE_W +: pa_pkg::SLICE_W]),
			.b(b[k*pa_pkg::SLICE_W +: pa_pkg::SLICE_W]),
			.fn((k < pa_pkg::SLICES/2) ? fn_hi : fn_lo),
			.logic_mode(logic_mode),
			.cin(c[k]),
			.f(f[k*pa_pkg::SLICE_W +: pa_pkg::SLICE_W]),
			.p(p[k]),
			.g(g[k]),
			.eq(eqv[k]),
			.cout(co[k])
		);
	end

	// 182-style lookahead, carries enter at the least significant slice
	assign c[3] = cin;
	assign c[2] = g[3] | (p[3] & cin);
	assign c[1] = g[2] | (p[2] & g[3]) | (p[2] & p[3] & cin);
	assign c[0] = g[1] | (p[1] & g[2]) | (p[1] & p[2] & g[3])
		| (p[1] & p[2] & p[3] & cin);

	assign carry = co[0];

endmodule

// File: src/pa_regs.sv
`timescale 1ns/1ps

module pa_regs (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic strob1,
	input  logic strob2,
	input  logic as2,
	input  logic w_ac,
	input  logic w_ar,
	input  logic w_ic,
	input  logic arp1,
	input  logic arm4,
	input  logic icp1,
	input  logic off,
	input  logic at_load,
	input  logic at_shift,
	input  logic eat0,
	input  pa_pkg::word_t w,
	input  pa_pkg::word_t f,
	output pa_pkg::word_t ac,
	output pa_pkg::word_t ar,
	output pa_pkg::word_t ic,
	output pa_pkg::word_t at,
	output logic arz
);

	logic strob;

	// as2 picks which strobe qualifies the register writes
	assign strob = as2 ? strob2 : strob1;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ac <= '0;
		end else if (w_ac && strob) begin
			ac <= w;
		end
	end

	// load wins over counting
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ar <= '0;
		end else if (w_ar && strob) begin
			ar <= w;
		end else if (arp1 && strob1) begin
			ar <= ar + 16'd1;
		end else if (arm4 && strob1) begin
			ar <= ar - pa_pkg::AR_STEP_DN;
		end
	end

	// off clears ic without waiting for the clock
	always_ff @(posedge clk_sys or negedge rst_n or posedge off) begin
		if (!rst_n) begin
			ic <= '0;
		end else if (off) begin
			ic <= '0;
		end else if (w_ic && strob) begin
			ic <= w;
		end else if (icp1 && strob1) begin
			ic <= ic + 16'd1;
		end
	end

	// shift moves toward bit 15, eat0 enters at bit 0
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			at <= '0;
		end else if (at_load && strob1) begin
			at <= f;
		end else if (at_shift && strob1) begin
			at <= {eat0, at[0:14]};
		end
	end

	assign arz = |ar[0:7];

endmodule

// File: src/pa_flags.sv
`timescale 1ns/1ps

module pa_flags (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic as2,
	input  logic strob1,
	input  logic am1,
	input  logic apb,
	input  logic amb,
	input  logic ap1,
	input  logic carry,
	input  pa_pkg::word_t f,
	input  logic a0,
	input  logic ac0,
	input  pa_pkg::nibble_t eqv,
	output logic s_1,
	output logic zs,
	output logic j,
	output logic wzi
);

	logic ext;

	// sign of the extended result, by operation class
	assign ext = (am1 & ~a0)
		| (apb & (a0 ^ ac0))
		| (amb & ~(a0 ^ ac0))
		| (ap1 & a0);

	assign s_1 = ~ext ^ ~carry;

	// zero only when the extension bit is clear too
	assign zs = (f == '0) & ~s_1;

	assign j = &eqv;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wzi <= 1'b0;
		end else if (as2 && strob1) begin
			wzi <= zs;
		end
	end

endmodule

// File: src/pa.sv
`timescale 1ns/1ps

module pa (
	input  logic clk_sys,
	input  logic rst_n,
	// W bus
	input  pa_pkg::word_t ir,
	input  pa_pkg::word_t ki,
	input  pa_pkg::word_t rdt,
	input  pa_pkg::word_t kl,
	input  pa_pkg::word_t l,
	input  pa_pkg::wsel_t wsel,
	input  logic blank_hi,
	input  logic blank_lo,
	input  logic w_dt,
	// A operand
	input  pa_pkg::asel_t asel,
	input  logic blank_a0,
	input  logic blank_a8,
	input  logic blank_a10,
	// ALU
	input  pa_pkg::alu_fn_t fn_hi,
	input  pa_pkg::alu_fn_t fn_lo,
	input  logic logic_mode,
	input  logic cin,
	// strobes and registers
	input  logic strob1,
	input  logic strob2,
	input  logic as2,
	input  logic w_ac,
	input  logic w_ar,
	input  logic w_ic,
	input  logic arp1,
	input  logic arm4,
	input  logic icp1,
	input  logic off,
	input  logic eat0,
	input  logic at_load,
	input  logic at_shift,
	// sign extension class
	input  logic am1,
	input  logic apb,
	input  logic amb,
	input  logic ap1,
	// address bus
	input  logic ar_ad,
	input  logic ic_ad,
	output pa_pkg::word_t w,
	output pa_pkg::word_t ddt,
	output pa_pkg::word_t f,
	output logic s0,
	output logic carry,
	output logic j,
	output logic s_1,
	output logic zs,
	output logic wzi,
	output logic arz,
	output pa_pkg::word_t dad
);

	pa_pkg::word_t a;
	pa_pkg::word_t ac;
	pa_pkg::word_t ar;
	pa_pkg::word_t ic;
	pa_pkg::word_t at;
	pa_pkg::nibble_t eqv;

	pa_wbus wbus0 (
		.ir(ir), .ki(ki), .rdt(rdt), .kl(kl),
		.a(a), .ac(ac), .at(at),
		.wsel(wsel), .blank_hi(blank_hi), .blank_lo(blank_lo), .w_dt(w_dt),
		.w(w), .ddt(ddt)
	);

	pa_amux amux0 (
		.l(l), .ir(ir), .ar(ar), .ic(ic), .asel(asel),
		.blank_a0(blank_a0), .blank_a8(blank_a8), .blank_a10(blank_a10),
		.a(a)
	);

	// b operand is always AC
	pa_alu alu0 (
		.a(a), .b(ac), .fn_hi(fn_hi), .fn_lo(fn_lo),
		.logic_mode(logic_mode), .cin(cin),
		.f(f), .carry(carry), .eqv(eqv)
	);

	pa_regs regs0 (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.strob1(strob1), .strob2(strob2), .as2(as2),
		.w_ac(w_ac), .w_ar(w_ar), .w_ic(w_ic),
		.arp1(arp1), .arm4(arm4), .icp1(icp1), .off(off),
		.at_load(at_load), .at_shift(at_shift), .eat0(eat0),
		.w(w), .f(f),
		.ac(ac), .ar(ar), .ic(ic), .at(at), .arz(arz)
	);

	pa_flags flags0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .as2(as2), .strob1(strob1),
		.am1(am1), .apb(apb), .amb(amb), .ap1(ap1), .carry(carry),
		.f(f), .a0(a[0]), .ac0(ac[0]), .eqv(eqv),
		.s_1(s_1), .zs(zs), .j(j), .wzi(wzi)
	);

	assign s0 = f[0];

	// AR and IC may both drive the address bus
	assign dad = ({16{ar_ad}} & ar) | ({16{ic_ad}} & ic);

endmodule

// File: sim/pa_tb.sv
`timescale 1ns/1ps

module pa_tb;

	localparam int N_REGS = 60;
	localparam int N_WBUS = 200;
	localparam int N_ALU = 400;
	localparam int N_FLAGS = 100;
	localparam int N_CNT = 200;
	// reset, reset check, two cycles per register write, tail
	localparam int TOTAL_VEC = 4 + 3 + 2 * N_REGS + N_WBUS + N_ALU + N_FLAGS + N_CNT + 4;
	localparam int TIMEOUT_NS = TOTAL_VEC * 4 * 2 + 200;

	logic clk_sys = 1'b0;
	logic rst_n;
	pa_pkg::word_t ir, ki, rdt, kl, l;
	pa_pkg::wsel_t wsel;
	logic blank_hi, blank_lo, w_dt;
	pa_pkg::asel_t asel;
	logic blank_a0, blank_a8, blank_a10;
	pa_pkg::alu_fn_t fn_hi, fn_lo;
	logic logic_mode, cin;
	logic strob1, strob2, as2, w_ac, w_ar, w_ic;
	logic arp1, arm4, icp1, off, eat0, at_load, at_shift;
	logic am1, apb, amb, ap1;
	logic ar_ad, ic_ad;
	pa_pkg::word_t w, ddt, f, dad;
	logic s0, carry, j, s_1, zs, wzi, arz;

	// register model and expected outputs
	pa_pkg::word_t m_ac, m_ar, m_ic, m_at;
	logic m_wzi;
	pa_pkg::word_t exp_a, exp_w, exp_f, exp_ddt, exp_dad;
	logic exp_c, exp_s1, exp_zs, exp_j;
	logic [16:0] alu_res;
	logic strob;
	int seed;
	string test_name;

	pa dut0 (.*);

	always #2 clk_sys = ~clk_sys;

	// 74181 arithmetic as two addends, first in the upper byte
	function automatic logic [15:0] addends(input logic [3:0] fn, input logic [7:0] a,
		input logic [7:0] b);
		case (fn)
			4'h0: return {a, 8'h00};
			4'h1: return {a | b, 8'h00};
			4'h2: return {a | ~b, 8'h00};
			4'h3: return {8'hff, 8'h00};
			4'h4: return {a, a & ~b};
			4'h5: return {a | b, a & ~b};
			4'h6: return {a, ~b};
			4'h7: return {a & ~b, 8'hff};
			4'h8: return {a, a & b};
			4'h9: return {a, b};
			4'ha: return {a | ~b, a & b};
			4'hb: return {a & b, 8'hff};
			4'hc: return {a, a};
			4'hd: return {a | b, a};
			4'he: return {a | ~b, a};
			default: return {a, 8'hff};
		endcase
	endfunction

	// 74181 logic table, active-high data
	function automatic logic [7:0] logic_fn(input logic [3:0] fn, input logic [7:0] a,
		input logic [7:0] b);
		case (fn)
			4'h0: return ~a;
			4'h1: return ~(a | b);
			4'h2: return ~a & b;
			4'h3: return 8'h00;
			4'h4: return ~(a & b);
			4'h5: return ~b;
			4'h6: return a ^ b;
			4'h7: return a & ~b;
			4'h8: return ~a | b;
			4'h9: return ~(a ^ b);
			4'ha: return b;
			4'hb: return a & b;
			4'hc: return 8'hff;
			4'hd: return a | ~b;
			4'he: return a | b;
			default: return a;
		endcase
	endfunction

	// carry out of the top byte above the 16-bit result
	function automatic logic [16:0] ref_alu(input pa_pkg::word_t a, input pa_pkg::word_t b,
		input logic [3:0] fn_h, input logic [3:0] fn_l, input logic lm, input logic ci);
		logic [15:0] pq;
		logic [8:0] s_lo;
		logic [8:0] s_hi;
		logic [7:0] f_hi;
		logic [7:0] f_lo;
		pq = addends(fn_l, a[8:15], b[8:15]);
		s_lo = {1'b0, pq[15:8]} + {1'b0, pq[7:0]} + {8'd0, ci};
		pq = addends(fn_h, a[0:7], b[0:7]);
		s_hi = {1'b0, pq[15:8]} + {1'b0, pq[7:0]} + {8'd0, s_lo[8]};
		// carry follows the arithmetic sum in logic mode too
		f_hi = lm ? logic_fn(fn_h, a[0:7], b[0:7]) : s_hi[7:0];
		f_lo = lm ? logic_fn(fn_l, a[8:15], b[8:15]) : s_lo[7:0];
		return {s_hi[8], f_hi, f_lo};
	endfunction

	function automatic pa_pkg::word_t ref_wbus(input logic [2:0] sel, input pa_pkg::word_t a,
		input pa_pkg::word_t ac, input pa_pkg::word_t at, input logic bh, input logic bl);
		pa_pkg::word_t r;
		case (sel)
			3'd0: r = a;
			3'd1: r = ac;
			3'd2: r = at;
			3'd3: r = ki;
			3'd4: r = {8'h00, ac[0:7]};
			3'd5: r = rdt;
			3'd6: r = kl;
			default: r = ir;
		endcase
		return r & {bh ? 8'h00 : 8'hff, bl ? 8'h00 : 8'hff};
	endfunction

	function automatic pa_pkg::word_t ref_amux(input logic [1:0] sel, input pa_pkg::word_t ar,
		input pa_pkg::word_t ic);
		pa_pkg::word_t r;
		case (sel)
			2'd0: r = l;
			2'd1: r = ar;
			2'd2: r = ic;
			default: r = {l[8:15], ir[8:15]};
		endcase
		return r & {blank_a0 ? 8'h00 : 8'hff, blank_a8 ? 2'b00 : 2'b11,
			blank_a10 ? 6'h00 : 6'h3f};
	endfunction

	function automatic logic ref_sign(input logic a0, input logic ac0, input logic c);
		logic ext;
		ext = (am1 && !a0) || (apb && (a0 != ac0)) || (amb && (a0 == ac0)) || (ap1 && a0);
		return !ext ^ !c;
	endfunction

	function automatic pa_pkg::word_t rand_word();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	task automatic note_mismatch(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		$display("mismatch in %s: %s expected %h, got %h", test_name, what, exp, act);
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic clear_controls();
		wsel = '0;
		blank_hi = 1'b0;
		blank_lo = 1'b0;
		w_dt = 1'b0;
		asel = '0;
		blank_a0 = 1'b0;
		blank_a8 = 1'b0;
		blank_a10 = 1'b0;
		fn_hi = '0;
		fn_lo = '0;
		logic_mode = 1'b0;
		cin = 1'b0;
		{strob1, strob2, as2, w_ac, w_ar, w_ic} = '0;
		{arp1, arm4, icp1, off, eat0, at_load, at_shift} = '0;
		{am1, apb, amb, ap1} = '0;
		ar_ad = 1'b0;
		ic_ad = 1'b0;
	endtask

	task automatic next_cycle();
		@(negedge clk_sys);
		clear_controls();
	endtask

	task automatic rand_operands();
		logic [31:0] r;
		r = $urandom;
		l = rand_word();
		ir = rand_word();
		asel = r[1:0];
		blank_a0 = r[2] & r[3];
		blank_a8 = r[4] & r[5];
		blank_a10 = r[6] & r[7];
		fn_hi = r[11:8];
		fn_lo = r[15:12];
		logic_mode = r[16];
		cin = r[17];
	endtask

	// compare on the rising edge, then advance the model
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			m_ac = '0;
			m_ar = '0;
			m_ic = '0;
			m_at = '0;
			m_wzi = 1'b0;
		end
		// off acts on ic without a clock
		if (off) begin
			m_ic = '0;
		end
		exp_a = ref_amux(asel, m_ar, m_ic);
		exp_w = ref_wbus(wsel, exp_a, m_ac, m_at, blank_hi, blank_lo);
		alu_res = ref_alu(exp_a, m_ac, fn_hi, fn_lo, logic_mode, cin);
		exp_f = alu_res[15:0];
		exp_c = alu_res[16];
		exp_s1 = ref_sign(exp_a[0], m_ac[0], exp_c);
		exp_zs = (exp_f == '0) && !exp_s1;
		exp_j = (exp_f == 16'hffff);
		exp_ddt = w_dt ? exp_w : '0;
		exp_dad = (ar_ad ? m_ar : '0) | (ic_ad ? m_ic : '0);

		assert (w === exp_w) else note_mismatch("w", exp_w, w);
		assert (ddt === exp_ddt) else note_mismatch("ddt", exp_ddt, ddt);
		assert (f === exp_f) else note_mismatch("f", exp_f, f);
		assert (s0 === exp_f[0]) else note_mismatch("s0", exp_f[0], s0);
		assert (carry === exp_c) else note_mismatch("carry", exp_c, carry);
		assert (j === exp_j) else note_mismatch("j", exp_j, j);
		assert (s_1 === exp_s1) else note_mismatch("s_1", exp_s1, s_1);
		assert (zs === exp_zs) else note_mismatch("zs", exp_zs, zs);
		assert (wzi === m_wzi) else note_mismatch("wzi", m_wzi, wzi);
		assert (arz === (m_ar[0:7] != 0)) else note_mismatch("arz", m_ar[0:7] != 0, arz);
		assert (dad === exp_dad) else note_mismatch("dad", exp_dad, dad);

		if (rst_n) begin
			strob = as2 ? strob2 : strob1;
			if (w_ac && strob) begin
				m_ac = exp_w;
			end
			if (w_ar && strob) begin
				m_ar = exp_w;
			end else if (arp1 && strob1) begin
				m_ar = m_ar + 16'd1;
			end else if (arm4 && strob1) begin
				m_ar = m_ar - 16'd4;
			end
			if (off) begin
				m_ic = '0;
			end else if (w_ic && strob) begin
				m_ic = exp_w;
			end else if (icp1 && strob1) begin
				m_ic = m_ic + 16'd1;
			end
			if (at_load && strob1) begin
				m_at = exp_f;
			end else if (at_shift && strob1) begin
				m_at = m_at >> 1;
				m_at[0] = eat0;
			end
			if (as2 && strob1) begin
				m_wzi = exp_zs;
			end
		end
	end

	task automatic check_reset_state();
		test_name = "reset";
		next_cycle();
		wsel = 3'd1;
		ar_ad = 1'b1;
		next_cycle();
		wsel = 3'd2;
		ic_ad = 1'b1;
		next_cycle();
		wsel = 3'd1;
		ar_ad = 1'b1;
		ic_ad = 1'b1;
	endtask

	task automatic test_reg_writes();
		logic [31:0] r;
		test_name = "register writes";
		for (int i = 0; i < N_REGS; i++) begin
			next_cycle();
			r = $urandom;
			wsel = 3'd3;
			ki = rand_word();
			as2 = r[0];
			strob1 = r[1];
			strob2 = r[2];
			w_ac = r[3];
			w_ar = r[4];
			w_ic = r[5];
			// read back ac on W and ar/ic on the address bus
			next_cycle();
			r = $urandom;
			wsel = 3'd1;
			ar_ad = r[0];
			ic_ad = r[1];
		end
	endtask

	task automatic test_wbus();
		logic [31:0] r;
		test_name = "w bus";
		for (int i = 0; i < N_WBUS; i++) begin
			next_cycle();
			rand_operands();
			r = $urandom;
			wsel = r[2:0];
			ki = rand_word();
			rdt = rand_word();
			kl = rand_word();
			blank_hi = r[3] & r[4];
			blank_lo = r[5] & r[6];
			w_dt = r[7];
			// keep ac and at moving so the byte swap sees real data
			w_ac = r[8];
			at_load = r[10];
			strob1 = r[11];
		end
	endtask

	task automatic test_alu();
		logic [31:0] r;
		test_name = "alu";
		for (int i = 0; i < N_ALU; i++) begin
			next_cycle();
			rand_operands();
			r = $urandom;
			wsel = 3'd3;
			ki = rand_word();
			w_ac = (r[1:0] == 2'd0);
			w_ar = r[2] & w_ac;
			w_ic = r[3] & w_ac;
			strob1 = w_ac;
		end
	endtask

	task automatic test_flags();
		logic [31:0] r;
		test_name = "flags";
		for (int i = 0; i < N_FLAGS; i++) begin
			next_cycle();
			rand_operands();
			r = $urandom;
			// zero result half the time so zs gets exercised
			if (r[0]) begin
				logic_mode = 1'b1;
				fn_hi = 4'h3;
				fn_lo = 4'h3;
			end
			{am1, apb, amb, ap1} = r[4:1];
			as2 = r[5];
			strob1 = r[6];
		end
	endtask

	task automatic test_counters();
		logic [31:0] r;
		test_name = "counters and at";
		for (int i = 0; i < N_CNT; i++) begin
			next_cycle();
			rand_operands();
			r = $urandom;
			arp1 = r[0];
			arm4 = r[1];
			icp1 = r[2];
			strob1 = r[3] | r[4];
			off = (r[8:5] == 4'd0);
			at_load = r[9] & r[10];
			at_shift = r[11];
			eat0 = r[12];
			wsel = 3'd2;
			ar_ad = r[13];
			ic_ad = r[14];
			w_ar = (r[18:15] == 4'd0);
		end
	endtask

	initial begin
		seed = 32'haffd_9211;
		void'($urandom(seed));
		test_name = "reset";
		rst_n = 1'b0;
		ir = '0;
		ki = '0;
		rdt = '0;
		kl = '0;
		l = '0;
		clear_controls();
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
		check_reset_state();
		test_reg_writes();
		test_wbus();
		test_alu();
		test_flags();
		test_counters();
		next_cycle();
		next_cycle();
		$display("=== PASS ===");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: list.f
src/pa_pkg.sv
src/pa_wbus.sv
src/pa_amux.sv
src/alu_slice.sv
src/pa_alu.sv
src/pa_regs.sv
src/pa_flags.sv
src/pa.sv
sim/pa_tb.sv
